// File: hw/rvDecodePkg.sv
`default_nettype none

package rvDecodePkg;

    localparam int XLEN      = 64;
    localparam int ILEN      = 32;
    localparam int REG_IDX_W = 5;
    localparam int REG_COUNT = 32;
    localparam int ERR_CNT_W = 8;

    typedef logic [XLEN-1:0]      xlenT;
    typedef logic [ILEN-1:0]      instrT;
    typedef logic [REG_IDX_W-1:0] regIdxT;
    typedef logic [2:0]           immKindT;
    typedef logic [5:0]           aluCtrlT;
    typedef logic [2:0]           branchT;
    typedef logic [1:0]           aluBSrcT;
    typedef logic [6:0]           opcodeT;

    // immediate formats, bit-sliced by immGen
    localparam immKindT IMM_I = 3'b000;
    localparam immKindT IMM_J = 3'b001;
    localparam immKindT IMM_S = 3'b010;
    localparam immKindT IMM_B = 3'b011;
    localparam immKindT IMM_U = 3'b101;

    localparam aluBSrcT ALUB_RS2  = 2'd0;
    localparam aluBSrcT ALUB_FOUR = 2'd1;
    localparam aluBSrcT ALUB_IMM  = 2'd2;

    localparam branchT BR_NONE = 3'b000;
    localparam branchT BR_JAL  = 3'b001;
    localparam branchT BR_JALR = 3'b010;

    localparam aluCtrlT ALU_LUI = 6'b001111; // pass operand B

    localparam opcodeT OPC_LOAD    = 7'b0000011;
    localparam opcodeT OPC_STORE   = 7'b0100011;
    localparam opcodeT OPC_OPIMM   = 7'b0010011;
    localparam opcodeT OPC_OPIMM32 = 7'b0011011;
    localparam opcodeT OPC_OP      = 7'b0110011;
    localparam opcodeT OPC_OP32    = 7'b0111011;
    localparam opcodeT OPC_LUI     = 7'b0110111;
    localparam opcodeT OPC_AUIPC   = 7'b0010111;
    localparam opcodeT OPC_JAL     = 7'b1101111;
    localparam opcodeT OPC_JALR    = 7'b1100111;
    localparam opcodeT OPC_BRANCH  = 7'b1100011;
    localparam opcodeT OPC_SYSTEM  = 7'b1110011;

    localparam instrT EBREAK_WORD = 32'h00100073;

    typedef struct packed {
        logic       regWr;
        logic       aluASrc;  // pc as operand A
        aluBSrcT    aluBSrc;
        aluCtrlT    aluCtrl;
        branchT     branch;
        logic       memRd;
        logic       memWr;
        logic       memToReg;
        logic [2:0] memOp;    // load/store funct3
    } ctrlT;

    typedef struct packed {
        ctrlT   ctrl;
        xlenT   imm;
        xlenT   rs1Data;
        xlenT   rs2Data;
        regIdxT rs1;
        regIdxT rs2;
        regIdxT rd;
        logic   pcRel;
    } idBundleT;

endpackage

`default_nettype wire

// File: hw/ctrlDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module ctrlDecoder (
    input  rvDecodePkg::instrT   instr,
    output rvDecodePkg::ctrlT    ctrl,
    output rvDecodePkg::immKindT immKind,
    output logic                 isEbreak,
    output logic                 illegal
);

    rvDecodePkg::opcodeT opcode;
    logic [2:0]          funct3;
    logic [6:0]          funct7;
    logic                isMulDiv;
    logic                f7Zero;
    logic                f7Alt;
    logic                opImmBad;
    logic                opImm32Ok;
    logic                opOk;
    logic                op32Ok;

    assign opcode   = instr[6:0];
    assign funct3   = instr[14:12];
    assign funct7   = instr[31:25];
    assign isEbreak = (instr == rvDecodePkg::EBREAK_WORD);
    assign isMulDiv = (funct7 == 7'b0000001);
    assign f7Zero   = (funct7 == 7'b0000000);
    assign f7Alt    = (funct7 == 7'b0100000);

    // shamt is 6 bits on OP-IMM, so only funct7[6:1] is checked
    assign opImmBad = ((funct3 == 3'b001) && (funct7[6:1] != 6'b000000))
                   || ((funct3 == 3'b101) && (funct7[6:1] != 6'b000000)
                       && (funct7[6:1] != 6'b010000));

    assign opImm32Ok = (funct3 == 3'b000)                        // addiw
                    || ((funct3 == 3'b001) && f7Zero)
                    || ((funct3 == 3'b101) && (f7Zero || f7Alt));

    assign opOk = f7Zero || isMulDiv
               || (f7Alt && ((funct3 == 3'b000) || (funct3 == 3'b101)));

    assign op32Ok = (f7Zero && ((funct3 == 3'b000) || (funct3 == 3'b001)
                                || (funct3 == 3'b101)))
                 || (f7Alt && ((funct3 == 3'b000) || (funct3 == 3'b101)))
                 || (isMulDiv && ((funct3 == 3'b000) || funct3[2])); // mulw, divw..remuw

    always_comb begin
        ctrl         = '0;
        ctrl.regWr   = 1'b1;
        ctrl.aluBSrc = rvDecodePkg::ALUB_IMM;
        ctrl.branch  = rvDecodePkg::BR_NONE;
        immKind      = rvDecodePkg::IMM_I;
        illegal      = 1'b0;
        case (opcode)
            rvDecodePkg::OPC_LOAD: begin
                ctrl.memRd    = 1'b1;
                ctrl.memToReg = 1'b1;
                ctrl.memOp    = funct3;
                illegal       = (funct3 == 3'b111);
            end
            rvDecodePkg::OPC_STORE: begin
                ctrl.regWr = 1'b0;
                ctrl.memWr = 1'b1;
                ctrl.memOp = funct3;
                immKind    = rvDecodePkg::IMM_S;
                illegal    = funct3[2];
            end
            rvDecodePkg::OPC_OPIMM: begin
                ctrl.aluCtrl = {2'b00, funct7[5] && (funct3 == 3'b101), funct3};
                illegal      = opImmBad;
            end
            rvDecodePkg::OPC_OPIMM32: begin
                ctrl.aluCtrl = {2'b01, funct7[5] && (funct3 == 3'b101), funct3};
                illegal      = !opImm32Ok;
            end
            rvDecodePkg::OPC_OP: begin
                ctrl.aluBSrc = rvDecodePkg::ALUB_RS2;
                ctrl.aluCtrl = {isMulDiv, 1'b0, funct7[5], funct3};
                illegal      = !opOk;
            end
            rvDecodePkg::OPC_OP32: begin
                ctrl.aluBSrc = rvDecodePkg::ALUB_RS2;
                ctrl.aluCtrl = {isMulDiv, 1'b1, funct7[5], funct3};
                illegal      = !op32Ok;
            end
            rvDecodePkg::OPC_LUI: begin
                ctrl.aluCtrl = rvDecodePkg::ALU_LUI;
                immKind      = rvDecodePkg::IMM_U;
            end
            rvDecodePkg::OPC_AUIPC: begin
                ctrl.aluASrc = 1'b1;
                immKind      = rvDecodePkg::IMM_U;
            end
            rvDecodePkg::OPC_JAL: begin
                ctrl.aluASrc = 1'b1;                    // link = pc + 4
                ctrl.aluBSrc = rvDecodePkg::ALUB_FOUR;
                ctrl.branch  = rvDecodePkg::BR_JAL;
                immKind      = rvDecodePkg::IMM_J;
            end
            rvDecodePkg::OPC_JALR: begin
                ctrl.aluASrc = 1'b1;
                ctrl.aluBSrc = rvDecodePkg::ALUB_FOUR;
                ctrl.branch  = rvDecodePkg::BR_JALR;
                illegal      = (funct3 != 3'b000);
            end
            rvDecodePkg::OPC_BRANCH: begin
                ctrl.regWr   = 1'b0;
                ctrl.aluBSrc = rvDecodePkg::ALUB_RS2;
                ctrl.aluCtrl = {5'b00001, funct3[1]};   // 011 for unsigned compare
                ctrl.branch  = {1'b1, funct3[2], funct3[0]};
                immKind      = rvDecodePkg::IMM_B;
                illegal      = (funct3[2:1] == 2'b01);
            end
            rvDecodePkg::OPC_SYSTEM: begin
                ctrl.regWr   = 1'b0;
                ctrl.aluBSrc = rvDecodePkg::ALUB_FOUR;
                illegal      = !isEbreak;               // ecall and csr ops unsupported
            end
            default: begin
                illegal = 1'b1;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: hw/immGen.sv
`timescale 1ns/1ps
`default_nettype none

module immGen (
    input  rvDecodePkg::instrT   instr,
    input  rvDecodePkg::immKindT immKind,
    output rvDecodePkg::xlenT    imm
);

    logic sign;
    logic isU;
    logic isJorU;

    assign sign   = instr[31];
    assign isU    = immKind[2];
    assign isJorU = !immKind[1] && immKind[0];

    assign imm[63:31] = {33{sign}};
    assign imm[30:20] = isU ? instr[30:20] : {11{sign}};
    assign imm[19:12] = isJorU ? instr[19:12] : {8{sign}};

    // bit 11 comes from a different field in every format
    assign imm[11] = isU         ? 1'b0     :
                     !immKind[0] ? sign     :
                     immKind[1]  ? instr[7] : instr[20];

    assign imm[10:5] = isU ? 6'b000000 : instr[30:25];

    assign imm[4:1] = isU        ? 4'b0000     :
                      immKind[1] ? instr[11:8] : instr[24:21]; // S/B use rd field

    assign imm[0] = immKind[0] ? 1'b0     :  // B, J, U
                    immKind[1] ? instr[7] : instr[20];

endmodule

`default_nettype wire

// File: hw/regFile.sv
`timescale 1ns/1ps
`default_nettype none

module regFile (
    input  logic                clk,
    input  logic                arstN,
    input  rvDecodePkg::regIdxT rs1,
    input  rvDecodePkg::regIdxT rs2,
    output rvDecodePkg::xlenT   rs1Data,
    output rvDecodePkg::xlenT   rs2Data,
    input  logic                wbValid,
    input  rvDecodePkg::regIdxT wbRd,
    input  rvDecodePkg::xlenT   wbData
);

    rvDecodePkg::xlenT regs [rvDecodePkg::REG_COUNT];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            regs <= '{default: '0};
        end else if (wbValid && (wbRd != '0)) begin
            regs[wbRd] <= wbData; // x0 never written
        end
    end

    // reads see the old value on a same-edge write
    assign rs1Data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2Data = (rs2 == '0) ? '0 : regs[rs2];

    wbRdKnown: assert property (
        @(posedge clk) disable iff (!arstN)
        wbValid |-> !$isunknown(wbRd)
    ) else $error("writeback index unknown while wbValid high");

endmodule

`default_nettype wire

// File: hw/decodeStatus.sv
`timescale 1ns/1ps
`default_nettype none

module decodeStatus (
    input  logic                                clk,
    input  logic                                arstN,
    input  logic                                instrValid,
    input  logic                                illegal,
    input  logic                                isEbreak,
    input  rvDecodePkg::instrT                  instr,
    output logic                                issue,
    output logic                                halted,
    output logic [rvDecodePkg::ERR_CNT_W-1:0]   errCount,
    output rvDecodePkg::instrT                  firstFault
);

    typedef enum logic {
        RUN,
        HALTED
    } runStateT;

    runStateT state;
    logic     inRun;
    logic     countIllegal;

    assign inRun        = (state == RUN);
    assign issue        = instrValid && !illegal && inRun;
    assign halted       = (state == HALTED);
    assign countIllegal = instrValid && illegal && inRun; // ignored once halted

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= RUN;
        end else if (issue && isEbreak) begin
            state <= HALTED; // left only through reset
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            errCount   <= '0;
            firstFault <= '0;
        end else if (countIllegal) begin
            if (errCount == '0) begin
                firstFault <= instr;
            end
            if (errCount != '1) begin
                errCount <= errCount + 1'b1; // saturating
            end
        end
    end

    haltSticky: assert property (
        @(posedge clk) disable iff (!arstN)
        halted |=> halted
    ) else $error("halted dropped without reset");

    errCountMonotonic: assert property (
        @(posedge clk) disable iff (!arstN)
        1'b1 |=> (errCount >= $past(errCount))
    ) else $error("errCount decreased");

endmodule

`default_nettype wire

// File: hw/decodeStage.sv
`timescale 1ns/1ps
`default_nettype none

module decodeStage (
    input  logic                              clk,
    input  logic                              arstN,
    input  logic                              instrValid,
    input  rvDecodePkg::instrT                instr,
    input  logic                              wbValid,
    input  rvDecodePkg::regIdxT               wbRd,
    input  rvDecodePkg::xlenT                 wbData,
    output logic                              outValid,
    output rvDecodePkg::idBundleT             outBundle,
    output logic                              halted,
    output logic [rvDecodePkg::ERR_CNT_W-1:0] errCount,
    output rvDecodePkg::instrT                firstFault
);

    rvDecodePkg::ctrlT     ctrl;
    rvDecodePkg::immKindT  immKind;
    rvDecodePkg::xlenT     imm;
    rvDecodePkg::xlenT     rs1Data;
    rvDecodePkg::xlenT     rs2Data;
    rvDecodePkg::regIdxT   rs1;
    rvDecodePkg::regIdxT   rs2;
    rvDecodePkg::regIdxT   rd;
    rvDecodePkg::opcodeT   opcode;
    rvDecodePkg::idBundleT bundleNext;
    logic                  isEbreak;
    logic                  illegal;
    logic                  issue;
    logic                  pcRel;

    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign rd     = instr[11:7];
    assign opcode = instr[6:0];
    assign pcRel  = (opcode == rvDecodePkg::OPC_AUIPC) || (opcode == rvDecodePkg::OPC_JAL)
                 || (opcode == rvDecodePkg::OPC_BRANCH); // target relative to pc

    ctrlDecoder uDecoder (
        .instr    (instr),
        .ctrl     (ctrl),
        .immKind  (immKind),
        .isEbreak (isEbreak),
        .illegal  (illegal)
    );

    immGen uImmGen (
        .instr   (instr),
        .immKind (immKind),
        .imm     (imm)
    );

    regFile uRegFile (
        .clk     (clk),
        .arstN   (arstN),
        .rs1     (rs1),
        .rs2     (rs2),
        .rs1Data (rs1Data),
        .rs2Data (rs2Data),
        .wbValid (wbValid),
        .wbRd    (wbRd),
        .wbData  (wbData)
    );

    decodeStatus uStatus (
        .clk        (clk),
        .arstN      (arstN),
        .instrValid (instrValid),
        .illegal    (illegal),
        .isEbreak   (isEbreak),
        .instr      (instr),
        .issue      (issue),
        .halted     (halted),
        .errCount   (errCount),
        .firstFault (firstFault)
    );

    assign bundleNext = '{
        ctrl:    ctrl,
        imm:     imm,
        rs1Data: rs1Data,
        rs2Data: rs2Data,
        rs1:     rs1,
        rs2:     rs2,
        rd:      rd,
        pcRel:   pcRel
    };

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            outValid <= 1'b0;
        end else begin
            outValid <= issue; // one pulse per accepted instr
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            outBundle <= bundleNext;
        end
    end

endmodule

`default_nettype wire

// File: dv/decodeStageTb.sv
`timescale 1ns/1ps
`default_nettype none

module decodeStageTb;

    localparam int RESET_CYCLES = 3;
    localparam int N_RANDOM     = 1500;
    localparam int N_HALTED     = 60;
    localparam int N_DRAIN      = 2;
    localparam int TOTAL_CYCLES = 2 * RESET_CYCLES + N_RANDOM + 1 + N_HALTED + N_DRAIN + 2;
    localparam int TIMEOUT_NS   = (TOTAL_CYCLES + 100) * 8;

    typedef struct packed {
        logic              legal;
        logic              ebreak;
        logic              pcRel;
        rvDecodePkg::ctrlT ctrl;
        rvDecodePkg::xlenT imm;
    } decodeT;

    typedef struct packed {
        logic                              valid;
        logic                              halted;
        logic [rvDecodePkg::ERR_CNT_W-1:0] errCount;
        rvDecodePkg::instrT                firstFault;
        rvDecodePkg::idBundleT             bundle;
    } expT;

    logic                              clk;
    logic                              arstN;
    logic                              instrValid;
    rvDecodePkg::instrT                instr;
    logic                              wbValid;
    rvDecodePkg::regIdxT               wbRd;
    rvDecodePkg::xlenT                 wbData;
    logic                              outValid;
    rvDecodePkg::idBundleT             outBundle;
    logic                              halted;
    logic [rvDecodePkg::ERR_CNT_W-1:0] errCount;
    rvDecodePkg::instrT                firstFault;

    integer                            seed;
    int                                checkCnt;
    int                                mismatchCnt;
    logic                              checking;
    logic                              expHalted;
    logic                              faultSeen;
    logic [rvDecodePkg::ERR_CNT_W-1:0] expErrCount;
    rvDecodePkg::instrT                expFirstFault;
    rvDecodePkg::instrT                nextInstr;
    rvDecodePkg::xlenT                 mirror [rvDecodePkg::REG_COUNT];
    expT                               expQ [$];

    decodeStage dut (
        .clk        (clk),
        .arstN      (arstN),
        .instrValid (instrValid),
        .instr      (instr),
        .wbValid    (wbValid),
        .wbRd       (wbRd),
        .wbData     (wbData),
        .outValid   (outValid),
        .outBundle  (outBundle),
        .halted     (halted),
        .errCount   (errCount),
        .firstFault (firstFault)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    // expected decode straight from the ISA formats
    function automatic decodeT refDecode(input rvDecodePkg::instrT w);
        decodeT     d;
        logic [2:0] f3;
        logic [6:0] f7;
        logic       mulDiv;
        f3     = w[14:12];
        f7     = w[31:25];
        mulDiv = (f7 == 7'b0000001);
        d              = '0;
        d.legal        = 1'b1;
        d.ctrl.regWr   = 1'b1;
        d.ctrl.aluBSrc = rvDecodePkg::ALUB_IMM;
        d.imm          = {{52{w[31]}}, w[31:20]}; // I format unless replaced
        case (w[6:0])
            rvDecodePkg::OPC_LOAD: begin
                d.legal         = (f3 != 3'd7);
                d.ctrl.memRd    = 1'b1;
                d.ctrl.memToReg = 1'b1;
                d.ctrl.memOp    = f3;
            end
            rvDecodePkg::OPC_STORE: begin
                d.legal       = (f3 < 3'd4);
                d.ctrl.regWr  = 1'b0;
                d.ctrl.memWr  = 1'b1;
                d.ctrl.memOp  = f3;
                d.imm         = {{52{w[31]}}, w[31:25], w[11:7]};
            end
            rvDecodePkg::OPC_OPIMM: begin
                if (f3 == 3'd1) begin
                    d.legal = (f7[6:1] == 6'b000000);
                end else if (f3 == 3'd5) begin
                    d.legal = (f7[6:1] == 6'b000000) || (f7[6:1] == 6'b010000);
                end
                d.ctrl.aluCtrl = {2'b00, (f3 == 3'd5) && f7[5], f3};
            end
            rvDecodePkg::OPC_OPIMM32: begin
                d.legal = (f3 == 3'd0) || ((f3 == 3'd1) && (f7 == 7'h00))
                       || ((f3 == 3'd5) && ((f7 == 7'h00) || (f7 == 7'h20)));
                d.ctrl.aluCtrl = {2'b01, (f3 == 3'd5) && f7[5], f3};
            end
            rvDecodePkg::OPC_OP: begin
                d.legal = (f7 == 7'h00) || mulDiv
                       || ((f7 == 7'h20) && ((f3 == 3'd0) || (f3 == 3'd5)));
                d.ctrl.aluBSrc = rvDecodePkg::ALUB_RS2;
                d.ctrl.aluCtrl = {mulDiv, 1'b0, f7[5], f3};
            end
            rvDecodePkg::OPC_OP32: begin
                d.legal = ((f7 == 7'h00) && ((f3 == 3'd0) || (f3 == 3'd1) || (f3 == 3'd5)))
                       || ((f7 == 7'h20) && ((f3 == 3'd0) || (f3 == 3'd5)))
                       || (mulDiv && ((f3 == 3'd0) || (f3 >= 3'd4)));
                d.ctrl.aluBSrc = rvDecodePkg::ALUB_RS2;
                d.ctrl.aluCtrl = {mulDiv, 1'b1, f7[5], f3};
            end
            rvDecodePkg::OPC_LUI: begin
                d.ctrl.aluCtrl = 6'b001111;
                d.imm          = {{32{w[31]}}, w[31:12], 12'h000};
            end
            rvDecodePkg::OPC_AUIPC: begin
                d.ctrl.aluASrc = 1'b1;
                d.pcRel        = 1'b1;
                d.imm          = {{32{w[31]}}, w[31:12], 12'h000};
            end
            rvDecodePkg::OPC_JAL: begin
                d.ctrl.aluASrc = 1'b1;
                d.ctrl.aluBSrc = rvDecodePkg::ALUB_FOUR;
                d.ctrl.branch  = 3'b001;
                d.pcRel        = 1'b1;
                d.imm          = {{43{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            end
            rvDecodePkg::OPC_JALR: begin
                d.legal        = (f3 == 3'd0);
                d.ctrl.aluASrc = 1'b1;
                d.ctrl.aluBSrc = rvDecodePkg::ALUB_FOUR;
                d.ctrl.branch  = 3'b010;
            end
            rvDecodePkg::OPC_BRANCH: begin
                d.legal        = (f3 != 3'd2) && (f3 != 3'd3);
                d.ctrl.regWr   = 1'b0;
                d.ctrl.aluBSrc = rvDecodePkg::ALUB_RS2;
                d.ctrl.aluCtrl = ((f3 == 3'd6) || (f3 == 3'd7)) ? 6'd3 : 6'd2;
                case (f3)
                    3'd0:       d.ctrl.branch = 3'b100;
                    3'd1:       d.ctrl.branch = 3'b101;
                    3'd4, 3'd6: d.ctrl.branch = 3'b110;
                    default:    d.ctrl.branch = 3'b111;
                endcase
                d.pcRel = 1'b1;
                d.imm   = {{51{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            end
            rvDecodePkg::OPC_SYSTEM: begin
                d.legal        = (w == rvDecodePkg::EBREAK_WORD);
                d.ebreak       = d.legal;
                d.ctrl.regWr   = 1'b0;
                d.ctrl.aluBSrc = rvDecodePkg::ALUB_FOUR;
            end
            default: begin
                d.legal = 1'b0;
            end
        endcase
        return d;
    endfunction

    task automatic genInstr(output rvDecodePkg::instrT w);
        int pick;
        int sel;
        w    = $random(seed);
        pick = $unsigned($random(seed)) % 100;
        sel  = $unsigned($random(seed)) % 16;
        if (pick < 10) begin
            w[6:0]   = rvDecodePkg::OPC_LOAD;
            w[14:12] = 3'(sel % 7);
        end else if (pick < 18) begin
            w[6:0]   = rvDecodePkg::OPC_STORE;
            w[14:12] = 3'(sel % 4);
        end else if (pick < 30) begin
            w[6:0] = rvDecodePkg::OPC_OPIMM;
            if (w[14:12] == 3'b001) begin
                w[31:26] = 6'b000000;
            end else if (w[14:12] == 3'b101) begin
                w[31:26] = sel[0] ? 6'b010000 : 6'b000000; // srai or srli
            end
        end else if (pick < 36) begin
            w[6:0]   = rvDecodePkg::OPC_OPIMM32;
            w[14:12] = (sel % 3 == 0) ? 3'b000 : (sel % 3 == 1) ? 3'b001 : 3'b101;
            if (w[14:12] != 3'b000) begin
                w[31:25] = ((w[14:12] == 3'b101) && sel[3]) ? 7'h20 : 7'h00;
            end
        end else if (pick < 48) begin
            w[6:0] = rvDecodePkg::OPC_OP;
            if (sel % 3 == 0) begin
                w[31:25] = 7'h00;
            end else if (sel % 3 == 1) begin
                w[31:25] = 7'h01;
            end else begin
                w[31:25] = 7'h20;
                w[14:12] = sel[3] ? 3'b101 : 3'b000;
            end
        end else if (pick < 54) begin
            w[6:0] = rvDecodePkg::OPC_OP32;
            if (sel % 3 == 0) begin
                w[31:25] = 7'h00;
                w[14:12] = w[14] ? 3'b101 : {2'b00, w[12]};
            end else if (sel % 3 == 1) begin
                w[31:25] = 7'h20;
                w[14:12] = w[14] ? 3'b101 : 3'b000;
            end else begin
                w[31:25] = 7'h01;
                w[14:12] = w[14] ? w[14:12] : 3'b000; // mulw or divw..remuw
            end
        end else if (pick < 58) begin
            w[6:0] = rvDecodePkg::OPC_LUI;
        end else if (pick < 61) begin
            w[6:0] = rvDecodePkg::OPC_AUIPC;
        end else if (pick < 65) begin
            w[6:0] = rvDecodePkg::OPC_JAL;
        end else if (pick < 68) begin
            w[6:0]   = rvDecodePkg::OPC_JALR;
            w[14:12] = 3'b000;
        end else if (pick < 78) begin
            w[6:0]   = rvDecodePkg::OPC_BRANCH;
            w[14:12] = (sel % 6 < 2) ? 3'(sel % 6) : 3'(sel % 6 + 2);
        end else if (pick < 90) begin
            case (sel % 9) // known opcode, random funct fields
                0:       w[6:0] = rvDecodePkg::OPC_LOAD;
                1:       w[6:0] = rvDecodePkg::OPC_STORE;
                2:       w[6:0] = rvDecodePkg::OPC_OPIMM;
                3:       w[6:0] = rvDecodePkg::OPC_OPIMM32;
                4:       w[6:0] = rvDecodePkg::OPC_OP;
                5:       w[6:0] = rvDecodePkg::OPC_OP32;
                6:       w[6:0] = rvDecodePkg::OPC_BRANCH;
                7:       w[6:0] = rvDecodePkg::OPC_JALR;
                default: w[6:0] = rvDecodePkg::OPC_SYSTEM;
            endcase
        end
        if (w == rvDecodePkg::EBREAK_WORD) begin
            w[20] = 1'b0; // keep halts out of the random mix
        end
    endtask

    // one strobe per call, expectation queued for the next cycle
    task automatic driveCycle(input logic valid, input rvDecodePkg::instrT w);
        decodeT              d;
        expT                 e;
        logic                doWb;
        rvDecodePkg::regIdxT wr;
        rvDecodePkg::xlenT   wd;
        @(posedge clk);
        d    = refDecode(w);
        doWb = ($unsigned($random(seed)) % 4) == 0;
        wr   = $random(seed);
        wd   = {$random(seed), $random(seed)};
        e       = '0;
        e.valid = valid && d.legal && !expHalted;
        if (valid && !expHalted) begin
            if (!d.legal) begin
                if (!faultSeen) begin
                    expFirstFault = w;
                end
                faultSeen = 1'b1;
                if (expErrCount != '1) begin
                    expErrCount = expErrCount + 1'b1;
                end
            end else if (d.ebreak) begin
                expHalted = 1'b1;
            end
        end
        e.halted         = expHalted;
        e.errCount       = expErrCount;
        e.firstFault     = expFirstFault;
        e.bundle.ctrl    = d.ctrl;
        e.bundle.imm     = d.imm;
        e.bundle.rs1Data = mirror[w[19:15]];
        e.bundle.rs2Data = mirror[w[24:20]];
        e.bundle.rs1     = w[19:15];
        e.bundle.rs2     = w[24:20];
        e.bundle.rd      = w[11:7];
        e.bundle.pcRel   = d.pcRel;
        expQ.push_back(e);
        instrValid <= valid;
        instr      <= w;
        wbValid    <= doWb;
        wbRd       <= wr;
        wbData     <= wd;
        if (doWb && (wr != '0)) begin
            mirror[wr] = wd; // x0 stays zero
        end
    endtask

    task automatic reportMismatch(input string name, input logic [63:0] got,
                                  input logic [63:0] exp);
        mismatchCnt++;
        $display("Mismatch %s at %0t: got %0h expected %0h", name, $time, got, exp);
    endtask

    task automatic checkWord(input string name, input rvDecodePkg::xlenT got,
                             input rvDecodePkg::xlenT exp);
        checkCnt++;
        if (got !== exp) begin
            reportMismatch(name, got, exp);
        end
    endtask

    task automatic checkInstr(input string name, input rvDecodePkg::instrT got,
                              input rvDecodePkg::instrT exp);
        checkCnt++;
        if (got !== exp) begin
            reportMismatch(name, got, exp);
        end
    endtask

    task automatic checkCount(input string name,
                              input logic [rvDecodePkg::ERR_CNT_W-1:0] got,
                              input logic [rvDecodePkg::ERR_CNT_W-1:0] exp);
        checkCnt++;
        if (got !== exp) begin
            reportMismatch(name, got, exp);
        end
    endtask

    task automatic checkFlag(input string name, input logic got, input logic exp);
        checkCnt++;
        if (got !== exp) begin
            reportMismatch(name, got, exp);
        end
    endtask

    task automatic checkBundle(input rvDecodePkg::idBundleT got,
                               input rvDecodePkg::idBundleT exp);
        checkCnt++;
        if (got.ctrl !== exp.ctrl) begin
            reportMismatch("outBundle.ctrl", got.ctrl, exp.ctrl);
        end
        checkWord("outBundle.imm", got.imm, exp.imm);
        checkWord("outBundle.rs1Data", got.rs1Data, exp.rs1Data);
        checkWord("outBundle.rs2Data", got.rs2Data, exp.rs2Data);
        if (got.rs1 !== exp.rs1) begin
            reportMismatch("outBundle.rs1", got.rs1, exp.rs1);
        end
        if (got.rs2 !== exp.rs2) begin
            reportMismatch("outBundle.rs2", got.rs2, exp.rs2);
        end
        if (got.rd !== exp.rd) begin
            reportMismatch("outBundle.rd", got.rd, exp.rd);
        end
        checkFlag("outBundle.pcRel", got.pcRel, exp.pcRel);
    endtask

    // outputs settle after the posedge, so compare mid-cycle
    always @(negedge clk) begin
        expT e;
        if (checking && (expQ.size() >= 2)) begin
            e = expQ.pop_front();
            checkFlag("outValid", outValid, e.valid);
            if (e.valid) begin
                checkBundle(outBundle, e.bundle);
            end
            checkFlag("halted", halted, e.halted);
            checkCount("errCount", errCount, e.errCount);
            checkInstr("firstFault", firstFault, e.firstFault);
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("timeout: stimulus did not finish within %0d ns", TIMEOUT_NS);
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        seed          = 32'h47d2;
        checkCnt      = 0;
        mismatchCnt   = 0;
        checking      = 1'b0;
        expHalted     = 1'b0;
        faultSeen     = 1'b0;
        expErrCount   = '0;
        expFirstFault = '0;
        arstN         = 1'b0;
        instrValid    = 1'b0;
        instr         = '0;
        wbValid       = 1'b0;
        wbRd          = '0;
        wbData        = '0;
        for (int i = 0; i < rvDecodePkg::REG_COUNT; i++) begin
            mirror[i] = '0;
        end
        repeat (RESET_CYCLES - 1) @(posedge clk);
        @(negedge clk);
        checkFlag("outValid", outValid, 1'b0); // no clocked load yet, only reset
        @(posedge clk);
        arstN    <= 1'b1;
        checking  = 1'b1;

        for (int n = 0; n < N_RANDOM; n++) begin
            genInstr(nextInstr);
            driveCycle(($unsigned($random(seed)) % 8) != 0, nextInstr);
        end

        driveCycle(1'b1, rvDecodePkg::EBREAK_WORD);
        for (int n = 0; n < N_HALTED; n++) begin
            genInstr(nextInstr); // all dropped once halted
            driveCycle(1'b1, nextInstr);
        end
        repeat (N_DRAIN) driveCycle(1'b0, '0);
        checking = 1'b0;
        expQ.delete();

        @(posedge clk);
        arstN      <= 1'b0;
        instrValid <= 1'b0;
        wbValid    <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        checkFlag("halted", halted, 1'b0);
        checkCount("errCount", errCount, '0);
        checkInstr("firstFault", firstFault, '0);
        @(posedge clk);
        arstN <= 1'b1;
        @(posedge clk);

        $display("checks: %0d, mismatches: %0d", checkCnt, mismatchCnt);
        if (mismatchCnt == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
hw/rvDecodePkg.sv
hw/ctrlDecoder.sv
hw/immGen.sv
hw/regFile.sv
hw/decodeStatus.sv
hw/decodeStage.sv
dv/decodeStageTb.sv

// File: Bender.yml
package:
  name: rv_decode_stage

sources:
  - files:
      - hw/rvDecodePkg.sv
      - hw/ctrlDecoder.sv
      - hw/immGen.sv
      - hw/regFile.sv
      - hw/decodeStatus.sv
      - hw/decodeStage.sv
  - target: test
    files:
      - dv/decodeStageTb.sv
